/* project.f */
+incdir+rtl
rtl/fifo_pkg.sv
rtl/fifo_stack_u.sv
rtl/fifo_stack.sv
rtl/fifo_axil_regs.sv
rtl/fifo_axil_top.sv
sim/fifo_assertions.sv
sim/fifo_tb.sv

/* run.sh */
#!/bin/sh
# Build the FIFO testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fifo_tb -f project.f \
    -o fifo_tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fifo_tb_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

/* sim/fifo_tb.sv */
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_tb;

    import fifo_pkg::*;

    localparam int TIMEOUT = 50;   // Cycles allowed for one handshake

    logic       clk;
    logic       rst_n;
    axil_addr_t s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axil_data_t s_axil_wdata;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    axil_resp_t s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_addr_t s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axil_data_t s_axil_rdata;
    axil_resp_t s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;

    fifo_word_t  model_q[$];   // Reference contents, head at index 0
    logic        ovf_model;    // Expected sticky flags
    logic        udf_model;
    logic [31:0] lcg_state;
    logic        timed_out;    // Set once, later bus tasks and checks do nothing
    int          errors;
    int          tests_run;
    int          tests_bad;

    fifo_axil_top fifo_axil_top_inst (.*);

    always #2 clk = ~clk;   // 4 ns period

    function automatic axil_data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Polls on falling edges, 0 AW/W ready, 1 BVALID, 2 ARREADY, 3 RVALID
    task automatic wait_for(input int sel, input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && !timed_out) begin
            @(negedge clk);
            case (sel)
                0:       seen = s_axil_awready & s_axil_wready;
                1:       seen = s_axil_bvalid;
                2:       seen = s_axil_arready;
                default: seen = s_axil_rvalid;
            endcase
            cycles++;
            if (!seen && cycles >= TIMEOUT) begin
                $display("Timeout at %0t ns, no %s from the DUT", $time, what);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input int ready_delay, output axil_resp_t resp);
        resp = AXIL_RESP_OKAY;
        if (timed_out) return;
        @(posedge clk);
        s_axil_awaddr  <= addr;
        s_axil_wdata   <= data;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        wait_for(0, "AWREADY/WREADY");
        @(posedge clk);                 // Handshake edge
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        wait_for(1, "BVALID");
        resp = s_axil_bresp;
        repeat (ready_delay) @(posedge clk);   // Back-pressure on B
        @(posedge clk);
        s_axil_bready <= 1'b1;
        @(posedge clk);
        s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, input int ready_delay,
                             output axil_data_t data, output axil_resp_t resp);
        data = '0;
        resp = AXIL_RESP_OKAY;
        if (timed_out) return;
        @(posedge clk);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        wait_for(2, "ARREADY");
        @(posedge clk);
        s_axil_arvalid <= 1'b0;
        wait_for(3, "RVALID");
        data = s_axil_rdata;
        resp = s_axil_rresp;
        repeat (ready_delay) @(posedge clk);   // Back-pressure on R
        @(posedge clk);
        s_axil_rready <= 1'b1;
        @(posedge clk);
        s_axil_rready <= 1'b0;
    endtask

    task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t exp);
        if (!timed_out && got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        if (!timed_out && got !== exp) begin
            $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input fifo_status_t got,
                                input fifo_status_t exp);
        if (!timed_out && got !== exp) begin
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // DATA write, model decides the response
    task automatic push_word(input fifo_word_t w, input int ready_delay);
        axil_resp_t resp;
        axil_resp_t exp;
        exp = AXIL_RESP_OKAY;
        if (model_q.size() == `FIFO_DEPTH) begin
            exp       = AXIL_RESP_SLVERR;   // Word refused
            ovf_model = 1'b1;
        end else begin
            model_q.push_back(w);
        end
        axil_write(axil_addr_t'(`REG_DATA), axil_data_t'(w), ready_delay, resp);
        check_resp("BRESP", resp, exp);
    endtask

    task automatic pop_word(input int ready_delay);
        axil_data_t data;
        axil_resp_t resp;
        fifo_word_t exp_w;
        axil_resp_t exp_r;
        exp_w = '0;
        exp_r = AXIL_RESP_OKAY;
        if (model_q.size() == 0) begin
            exp_r     = AXIL_RESP_SLVERR;   // Empty read returns 0
            udf_model = 1'b1;
        end else begin
            exp_w = model_q.pop_front();
        end
        axil_read(axil_addr_t'(`REG_DATA), ready_delay, data, resp);
        check_word("RDATA", fifo_word_t'(data), exp_w);
        check_resp("RRESP", resp, exp_r);
    endtask

    task automatic status_matches_model();
        axil_data_t   data;
        axil_resp_t   resp;
        fifo_status_t exp;
        exp.full      = (model_q.size() == `FIFO_DEPTH);
        exp.empty     = (model_q.size() == 0);
        exp.overflow  = ovf_model;
        exp.underflow = udf_model;
        axil_read(axil_addr_t'(`REG_STATUS), 0, data, resp);
        check_status("STATUS", fifo_status_t'(data[3:0]), exp);
        check_resp("STATUS RRESP", resp, AXIL_RESP_OKAY);
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors || timed_out) tests_bad++;
        if (timed_out) $display("%-14s aborted", name);
        else if (errors != start_errors) $display("%-14s mismatch", name);
        else $display("%-14s ok", name);
    endtask

    task automatic test_reset_state();
        int start;
        start = errors;
        status_matches_model();   // Empty only
        end_test("reset_state", start);
    endtask

    task automatic test_fill_drain(input string name, input logic extra);
        int start;
        start = errors;
        for (int i = 0; i < `FIFO_DEPTH; i++) push_word(fifo_word_t'(lcg_next() >> 16), 0);
        if (extra) push_word(fifo_word_t'(lcg_next() >> 16), 0);   // Overflow attempt
        status_matches_model();
        for (int i = 0; i < `FIFO_DEPTH; i++) pop_word(0);
        status_matches_model();
        end_test(name, start);
    endtask

    task automatic test_underflow();
        int         start;
        axil_resp_t resp;
        start = errors;
        pop_word(0);
        status_matches_model();   // Both sticky flags up
        axil_write(axil_addr_t'(`REG_STATUS), 32'hC, 0, resp);
        check_resp("BRESP", resp, AXIL_RESP_OKAY);
        ovf_model = 1'b0;
        udf_model = 1'b0;
        status_matches_model();
        end_test("underflow", start);
    endtask

    task automatic test_clear();
        int         start;
        axil_resp_t resp;
        start = errors;
        for (int i = 0; i < 3; i++) push_word(fifo_word_t'(lcg_next() >> 16), 0);
        axil_write(axil_addr_t'(`REG_CONTROL), 32'h1, 0, resp);
        check_resp("BRESP", resp, AXIL_RESP_OKAY);
        model_q.delete();
        status_matches_model();
        push_word(fifo_word_t'(lcg_next() >> 16), 0);
        pop_word(0);
        status_matches_model();
        end_test("clear", start);
    endtask

    task automatic test_random_mix();
        int         start;
        axil_data_t r;
        axil_data_t data;
        axil_resp_t resp;
        start = errors;
        for (int i = 0; i < 48; i++) begin
            r = lcg_next();
            if (r[31]) push_word(r[23:16], int'(r[30:28]));   // Up to 7 cycles of BREADY delay
            else pop_word(int'(r[30:28]));   // Up to 7 cycles of RREADY delay
        end
        while (model_q.size() > 0) pop_word(1);
        axil_write(axil_addr_t'('hC), 32'h0, 0, resp);   // Unmapped offset
        check_resp("BRESP", resp, AXIL_RESP_SLVERR);
        axil_read(axil_addr_t'('hC), 0, data, resp);
        check_resp("RRESP", resp, AXIL_RESP_SLVERR);
        status_matches_model();
        end_test("random_mix", start);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        ovf_model      = 1'b0;
        udf_model      = 1'b0;
        lcg_state      = 32'd26;
        timed_out      = 1'b0;
        errors         = 0;
        tests_run      = 0;
        tests_bad      = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_fill_drain("fill_drain", 1'b0);
        test_fill_drain("overflow", 1'b1);
        test_underflow();
        test_clear();
        test_random_mix();
        $display("%0d tests run, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/fifo_assertions.sv */
`timescale 1ns/10ps

// Protocol and flag checks on the FIFO top level
module fifo_assertions (
    input logic clk,
    input logic rst_n,
    input logic s_axil_bvalid,
    input logic s_axil_bready,
    input logic s_axil_rvalid,
    input logic s_axil_rready,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty
);

    // Responses stay up until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("BVALID dropped before BREADY");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("RVALID dropped before RREADY");

    a_flags_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else $error("FIFO reports full and empty at once");

    // Gating lives in the register block
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push asserted while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("pop asserted while empty");

endmodule

bind fifo_axil_top fifo_assertions fifo_assertions_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready),
    .push          (push),
    .pop           (pop),
    .full          (full),
    .empty         (empty)
);

/* rtl/fifo_axil_top.sv */
`timescale 1ns/10ps
`include "fifo_params.svh"

// FIFO with its AXI4-Lite host port
module fifo_axil_top (
    input  logic                 clk,              // Master clock
    input  logic                 rst_n,            // Sync reset, active low
    // Write side
    input  fifo_pkg::axil_addr_t s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  fifo_pkg::axil_data_t s_axil_wdata,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output fifo_pkg::axil_resp_t s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    // Read side
    input  fifo_pkg::axil_addr_t s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output fifo_pkg::axil_data_t s_axil_rdata,
    output fifo_pkg::axil_resp_t s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready
);

    import fifo_pkg::*;

    logic       push;        // Gated in the register block
    logic       pop;
    logic       clear;
    fifo_word_t push_data;
    fifo_word_t head;        // Always the oldest word
    logic       full;
    logic       empty;

    fifo_axil_regs fifo_axil_regs_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .push           (push),
        .pop            (pop),
        .clear          (clear),
        .push_data      (push_data),
        .head           (head),
        .full           (full),
        .empty          (empty)
    );

    fifo_stack #(
        .STACK_SIZE  (`FIFO_DEPTH),
        .STACK_WIDTH (`FIFO_WIDTH)
    ) fifo_stack_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_data (push_data),
        .save   (push),
        .pop    (pop),
        .clear  (clear),
        .o_data (head),
        .full   (full),
        .empty  (empty)
    );

endmodule

/* rtl/fifo_axil_regs.sv */
`timescale 1ns/10ps
`include "fifo_params.svh"

// AXI4-Lite register front end for the word FIFO
// One transaction in flight per direction, response held until accepted
module fifo_axil_regs (
    input  logic                 clk,              // Master clock
    input  logic                 rst_n,            // Sync reset, active low
    // Write address and data, taken together
    input  fifo_pkg::axil_addr_t s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  fifo_pkg::axil_data_t s_axil_wdata,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    // Write response
    output fifo_pkg::axil_resp_t s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    // Read address and response
    input  fifo_pkg::axil_addr_t s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output fifo_pkg::axil_data_t s_axil_rdata,
    output fifo_pkg::axil_resp_t s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,
    // FIFO side
    output logic                 push,             // Store push_data, never when full
    output logic                 pop,              // Drop head, never when empty
    output logic                 clear,            // Empty the FIFO
    output fifo_pkg::fifo_word_t push_data,
    input  fifo_pkg::fifo_word_t head,             // Current head word
    input  logic                 full,
    input  logic                 empty
);

    import fifo_pkg::*;

    axil_wr_req_t wr_req;         // Address and data seen on the write handshake
    logic         wr_fire;        // AW and W accepted this cycle
    logic         wr_is_data;
    logic         wr_is_status;
    logic         wr_is_ctrl;
    logic         bvalid_q;
    axil_resp_t   bresp_q;

    logic         ar_fire;        // AR accepted this cycle
    logic         rd_is_data;
    logic         rd_is_status;
    logic         rd_is_ctrl;
    logic         rvalid_q;
    axil_rd_rsp_t rd_rsp_d;       // Response formed on the AR edge
    axil_rd_rsp_t rd_rsp_q;

    logic         overflow_q;     // Sticky, push refused on full
    logic         underflow_q;    // Sticky, pop refused on empty
    fifo_status_t status_img;

    // Write channel
    // Both channels must be valid, and the previous response gone
    assign wr_fire        = s_axil_awvalid & s_axil_wvalid & ~bvalid_q;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign wr_req         = '{addr: s_axil_awaddr, data: s_axil_wdata};

    assign wr_is_data   = (wr_req.addr == axil_addr_t'(`REG_DATA));
    assign wr_is_status = (wr_req.addr == axil_addr_t'(`REG_STATUS));
    assign wr_is_ctrl   = (wr_req.addr == axil_addr_t'(`REG_CONTROL));

    assign push      = wr_fire & wr_is_data & ~full;          // Full blocks the push here
    assign clear     = wr_fire & wr_is_ctrl & wr_req.data[`CONTROL_CLR_BIT];
    assign push_data = fifo_word_t'(wr_req.data);             // Low bits only

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;                  // Response one cycle after handshake
        end else if (s_axil_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (wr_is_data && full) begin
                bresp_q <= AXIL_RESP_SLVERR;   // Word dropped
            end else if (!(wr_is_data || wr_is_status || wr_is_ctrl)) begin
                bresp_q <= AXIL_RESP_SLVERR;   // Unmapped offset
            end else begin
                bresp_q <= AXIL_RESP_OKAY;
            end
        end
    end

    assign s_axil_bvalid = bvalid_q;
    assign s_axil_bresp  = bresp_q;

    // Read channel
    assign s_axil_arready = ~rvalid_q;         // Free while no response waits
    assign ar_fire        = s_axil_arvalid & ~rvalid_q;

    assign rd_is_data   = (s_axil_araddr == axil_addr_t'(`REG_DATA));
    assign rd_is_status = (s_axil_araddr == axil_addr_t'(`REG_STATUS));
    assign rd_is_ctrl   = (s_axil_araddr == axil_addr_t'(`REG_CONTROL));

    assign pop = ar_fire & rd_is_data & ~empty;   // Head is sampled on this same edge

    assign status_img = '{
        underflow: underflow_q,
        overflow:  overflow_q,
        empty:     empty,
        full:      full
    };

    always_comb begin
        rd_rsp_d = '{data: '0, resp: AXIL_RESP_OKAY};
        if (rd_is_data) begin
            if (empty) begin
                rd_rsp_d.resp = AXIL_RESP_SLVERR;      // Nothing to pop, data stays 0
            end else begin
                rd_rsp_d.data = axil_data_t'(head);
            end
        end else if (rd_is_status) begin
            rd_rsp_d.data = axil_data_t'(status_img);  // Zero extended image
        end else if (!rd_is_ctrl) begin
            rd_rsp_d.resp = AXIL_RESP_SLVERR;          // Control reads 0 with OKAY
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (s_axil_rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_rsp_q <= rd_rsp_d;
        end
    end

    assign s_axil_rvalid = rvalid_q;
    assign s_axil_rdata  = rd_rsp_q.data;
    assign s_axil_rresp  = rd_rsp_q.resp;

    // Sticky error flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else begin
            if (wr_fire && wr_is_data && full) begin
                overflow_q <= 1'b1;
            end else if (wr_fire && wr_is_status && wr_req.data[`STATUS_OVF_BIT]) begin
                overflow_q <= 1'b0;
            end
            // A new underflow wins over a clear in the same cycle
            if (ar_fire && rd_is_data && empty) begin
                underflow_q <= 1'b1;
            end else if (wr_fire && wr_is_status && wr_req.data[`STATUS_UDF_BIT]) begin
                underflow_q <= 1'b0;
            end
        end
    end

endmodule

/* rtl/fifo_stack.sv */
`timescale 1ns/10ps
`include "fifo_params.svh"

// Word FIFO built from STACK_WIDTH identical bit slices
module fifo_stack #(
    parameter int STACK_SIZE  = `FIFO_DEPTH,   // Rows per slice
    parameter int STACK_WIDTH = `FIFO_WIDTH    // Slices, one per word bit
) (
    input  logic                 clk,      // Master clock
    input  logic                 rst_n,    // Sync reset, active low
    input  fifo_pkg::fifo_word_t i_data,   // Word stored on save
    input  logic                 save,     // Store i_data
    input  logic                 pop,      // Drop the head word
    input  logic                 clear,    // Empty every slice
    output fifo_pkg::fifo_word_t o_data,   // Head word
    output logic                 full,     // Word level full
    output logic                 empty     // Word level empty
);

    logic [STACK_WIDTH-1:0] slice_full;    // Per slice flags
    logic [STACK_WIDTH-1:0] slice_empty;

    // Every slice sees the same controls, so they move in lock step
    for (genvar i = 0; i < STACK_WIDTH; i++) begin : g_slice
        fifo_stack_u #(
            .STACK_SIZE (STACK_SIZE)
        ) fifo_stack_u_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .i_bit (i_data[i]),
            .save  (save),
            .pop   (pop),
            .clear (clear),
            .o_bit (o_data[i]),
            .full  (slice_full[i]),
            .empty (slice_empty[i])
        );
    end

    // Slices agree, any one of them reports for the word
    assign full  = |slice_full;
    assign empty = |slice_empty;

endmodule

/* rtl/fifo_stack_u.sv */
`timescale 1ns/10ps
`include "fifo_params.svh"

// Single bit slice of the word FIFO
// Rows shift toward row 0 on pop, new bits land in the first free row
module fifo_stack_u #(
    parameter int STACK_SIZE = `FIFO_DEPTH     // Rows in the slice, 2 or more
) (
    input  logic clk,      // Master clock
    input  logic rst_n,    // Sync reset, active low
    input  logic i_bit,    // Bit stored on save
    input  logic save,     // Write i_bit into the first free row
    input  logic pop,      // Drop row 0 and shift the rest down
    input  logic clear,    // Invalidate every row
    output logic o_bit,    // Head row, always visible
    output logic full,     // Last row holds data
    output logic empty     // Row 0 holds nothing
);

    logic [STACK_SIZE-1:0] row_data;     // Row 0 is the head
    logic [STACK_SIZE-1:0] row_valid;    // Thermometer code, filled from row 0 up
    logic [STACK_SIZE-1:0] shift_data;   // Rows after an optional pop
    logic [STACK_SIZE-1:0] shift_valid;
    logic [STACK_SIZE-1:0] free_row;     // One-hot, lowest invalid row after the shift

    // Pop first, so a save in the same cycle sees the rows already moved
    always_comb begin
        shift_data  = row_data;
        shift_valid = row_valid;
        if (pop) begin
            shift_data  = {1'b0, row_data[STACK_SIZE-1:1]};
            shift_valid = {1'b0, row_valid[STACK_SIZE-1:1]};
        end
    end

    // Row i is free when it is empty and the row below is taken
    // All zero when the slice stays full, so a save is dropped there
    assign free_row = ~shift_valid & {shift_valid[STACK_SIZE-2:0], 1'b1};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            row_valid <= '0;                        // Stack reset
        end else if (save) begin
            row_valid <= shift_valid | free_row;    // Claim the free row
        end else begin
            row_valid <= shift_valid;
        end
    end

    // Data rows carry no reset, valid bits qualify them
    always_ff @(posedge clk) begin
        if (save) begin
            row_data <= (shift_data & ~free_row) | ({STACK_SIZE{i_bit}} & free_row);
        end else begin
            row_data <= shift_data;
        end
    end

    assign o_bit = row_data[0];
    assign full  = row_valid[STACK_SIZE-1];
    assign empty = ~row_valid[0];

endmodule

/* rtl/fifo_pkg.sv */
`include "fifo_params.svh"

package fifo_pkg;

    // Payload widths
    typedef logic [`FIFO_WIDTH-1:0]  fifo_word_t;   // One stored word
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;   // Byte address on the host bus
    typedef logic [31:0]             axil_data_t;   // AXI4-Lite data lane
    typedef logic [1:0]              axil_resp_t;   // BRESP / RRESP code

    // Response codes used by the register block
    localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
    localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

    // Write request, taken when AW and W handshake together
    typedef struct packed {
        axil_addr_t addr;   // Register offset
        axil_data_t data;   // Full word, strobes not used
    } axil_wr_req_t;

    // Read response as held on the R channel
    typedef struct packed {
        axil_data_t data;   // RDATA
        axil_resp_t resp;   // RRESP
    } axil_rd_rsp_t;

    // STATUS register image, full sits at bit 0
    typedef struct packed {
        logic underflow;    // Bit 3, sticky, pop seen while empty
        logic overflow;     // Bit 2, sticky, push seen while full
        logic empty;        // Bit 1
        logic full;         // Bit 0
    } fifo_status_t;

endpackage

/* rtl/fifo_params.svh */
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// FIFO geometry
`define FIFO_DEPTH 8        // Rows per bit slice
`define FIFO_WIDTH 8        // Bits per word, one slice per bit

// AXI4-Lite host port
`define AXIL_ADDR_W 4       // Byte address width, covers three word registers

// Register map, byte offsets
// DATA    write pushes a word, read pops the head
// STATUS  bit 0 full, bit 1 empty, bit 2 overflow, bit 3 underflow
// CONTROL bit 0 clears the FIFO, reads as 0
`define REG_DATA    'h0
`define REG_STATUS  'h4
`define REG_CONTROL 'h8

// Sticky flag positions in STATUS, write one to clear
`define STATUS_OVF_BIT 2
`define STATUS_UDF_BIT 3

// Control bit positions
`define CONTROL_CLR_BIT 0   // Drops every stored word

`endif
